/* include/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// one buffer entry per reorder-buffer tag
`define LSU_ENTRIES 8

// tag width, enough to index every entry
`define LSU_TAG_W 3

// data and address width
`define LSU_XLEN 32

// data memory depth in 32-bit words
`define LSU_MEM_WORDS 64

// edges from request acceptance to the done pulse
`define LSU_MEM_LAT 2

`endif

/* lsu.f */
+incdir+include
rtl/lsu_pkg.sv
rtl/load_store_buffer.sv
rtl/data_mem.sv
rtl/lsu_top.sv
test/lsu_props.sv
test/lsu_tb.sv

/* rtl/data_mem.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module data_mem (
    input  logic               clk,
    input  logic               reset,
    input  lsu_pkg::mem_req_t  mem_req,
    output lsu_pkg::mem_resp_t mem_resp,
    output logic               mem_idle
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int CNT_W = $clog2(`LSU_MEM_LAT + 1);

    logic [`LSU_XLEN-1:0] mem_q [`LSU_MEM_WORDS];
    logic [3:0]           wr_be;
    logic [`LSU_XLEN-1:0] wr_data;
    lsu_pkg::mem_req_t    load_q;
    logic                 pending_q;
    logic                 store_hold_q;
    logic [CNT_W-1:0]     cnt_q;
    logic [`LSU_XLEN-1:0] rd_word;
    logic [`LSU_XLEN-1:0] rd_shift;
    logic [`LSU_XLEN-1:0] rd_data;

    // replicate store data across the lanes, little endian
    always_comb begin
        case (mem_req.size)
            lsu_pkg::size_byte: begin
                wr_be   = 4'b0001 << mem_req.addr[1:0];
                wr_data = {4{mem_req.wdata[7:0]}};
            end
            lsu_pkg::size_half: begin
                wr_be   = 4'b0011 << {mem_req.addr[1], 1'b0};
                wr_data = {2{mem_req.wdata[15:0]}};
            end
            default: begin
                wr_be   = 4'b1111;
                wr_data = mem_req.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (mem_req.valid && mem_req.store) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    mem_q[mem_req.addr[IDX_W+1:2]][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // load latency counter
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q    <= 1'b0;
            store_hold_q <= 1'b0;
            cnt_q        <= '0;
        end else begin
            store_hold_q <= mem_req.valid && mem_req.store;
            if (mem_req.valid && !mem_req.store) begin
                pending_q <= 1'b1;
                cnt_q     <= CNT_W'(`LSU_MEM_LAT - 1);
            end else if (pending_q) begin
                if (cnt_q == '0) begin
                    pending_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.valid && !mem_req.store) begin
            load_q <= mem_req;
        end
    end

    assign rd_word  = mem_q[load_q.addr[IDX_W+1:2]];
    assign rd_shift = rd_word >> {load_q.addr[1:0], 3'b000};

    always_comb begin
        case (load_q.size)
            lsu_pkg::size_byte:
                rd_data = {{(`LSU_XLEN-8){load_q.sign & rd_shift[7]}}, rd_shift[7:0]};
            lsu_pkg::size_half:
                rd_data = {{(`LSU_XLEN-16){load_q.sign & rd_shift[15]}}, rd_shift[15:0]};
            default:
                rd_data = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        mem_resp.done  <= pending_q && cnt_q == '0;
        mem_resp.tag   <= load_q.tag;
        mem_resp.rdata <= rd_data;
        if (reset) begin
            mem_resp.done <= 1'b0;
        end
    end

    // busy in the request cycle itself, during a load, and one cycle after a store
    assign mem_idle = !pending_q && !store_hold_q && !mem_req.valid;

endmodule

/* rtl/load_store_buffer.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_store_buffer (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  lsu_pkg::dispatch_t dispatch,
    input  lsu_pkg::bcast_t    ex_bcast,
    input  lsu_pkg::commit_t   commit,
    input  logic               mem_idle,
    input  lsu_pkg::mem_resp_t mem_resp,
    output lsu_pkg::mem_req_t  mem_req,
    output lsu_pkg::bcast_t    result,
    output logic               full
);

    localparam int N = `LSU_ENTRIES;

    function automatic logic is_load(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw,
                          lsu_pkg::op_lbu, lsu_pkg::op_lhu};
    endfunction

    function automatic logic is_store(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};
    endfunction

    function automatic lsu_pkg::mem_size_e op_size(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return lsu_pkg::size_byte;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return lsu_pkg::size_half;
            default: return lsu_pkg::size_word;
        endcase
    endfunction

    // only lb and lh extend the sign bit
    function automatic logic op_signed(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::op_lb, lsu_pkg::op_lh};
    endfunction

    // capture a waiting operand from either broadcast
    function automatic lsu_pkg::operand_t wake(
        input lsu_pkg::operand_t opnd,
        input lsu_pkg::bcast_t   ex,
        input lsu_pkg::bcast_t   own
    );
        lsu_pkg::operand_t res;
        res = opnd;
        if (!opnd.ready) begin
            if (ex.valid && ex.tag == opnd.tag) begin
                res.ready = 1'b1;
                res.value = ex.data;
            end else if (own.valid && own.tag == opnd.tag) begin
                res.ready = 1'b1;
                res.value = own.data;
            end
        end
        return res;
    endfunction

    logic [N-1:0]          occupied;
    logic [N-1:0]          issued;
    lsu_pkg::mem_op_e      op_q  [N];
    logic [`LSU_XLEN-1:0]  imm_q [N];
    lsu_pkg::operand_t     rs1_q [N];
    lsu_pkg::operand_t     rs2_q [N];

    logic                  dispatch_take;
    logic                  store_hit;
    logic                  issue_store;
    logic                  issue_load;
    logic                  load_found;
    logic [`LSU_TAG_W-1:0] load_sel;
    logic [`LSU_TAG_W-1:0] issue_tag;
    logic                  done_hit;
    lsu_pkg::mem_req_t     req_next;

    assign dispatch_take = dispatch.valid && (is_load(dispatch.op) || is_store(dispatch.op));

    // committed store with both operands in hand
    assign store_hit = commit.valid && occupied[commit.tag] && is_store(op_q[commit.tag])
                       && rs1_q[commit.tag].ready && rs2_q[commit.tag].ready;

    // scan downward so the lowest ready tag wins
    always_comb begin
        load_found = 1'b0;
        load_sel   = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (occupied[i] && !issued[i] && is_load(op_q[i]) && rs1_q[i].ready) begin
                load_found = 1'b1;
                load_sel   = `LSU_TAG_W'(i);
            end
        end
    end

    // a pending commit holds off loads even while memory is busy
    assign issue_store = mem_idle && store_hit;
    assign issue_load  = mem_idle && !store_hit && load_found;
    assign issue_tag   = issue_store ? commit.tag : load_sel;

    // stale responses for flushed or reused tags fall through here
    assign done_hit = mem_resp.done && occupied[mem_resp.tag] && issued[mem_resp.tag];

    assign full = &occupied;

    always_comb begin
        req_next.valid = issue_store || issue_load;
        req_next.store = issue_store;
        req_next.tag   = issue_tag;
        req_next.size  = op_size(op_q[issue_tag]);
        req_next.sign  = op_signed(op_q[issue_tag]);
        req_next.addr  = rs1_q[issue_tag].value + imm_q[issue_tag];
        req_next.wdata = rs2_q[issue_tag].value;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            occupied <= '0;
            issued   <= '0;
        end else begin
            if (done_hit) begin
                occupied[mem_resp.tag] <= 1'b0;
            end
            // store leaves as soon as it is sent
            if (issue_store) begin
                occupied[commit.tag] <= 1'b0;
            end
            if (issue_load) begin
                issued[load_sel] <= 1'b1;
            end
            if (dispatch_take) begin
                occupied[dispatch.tag] <= 1'b1;
                issued[dispatch.tag]   <= 1'b0;
            end
        end
    end

    // entry payload, woken every cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            rs1_q[i] <= wake(rs1_q[i], ex_bcast, result);
            rs2_q[i] <= wake(rs2_q[i], ex_bcast, result);
        end
        if (dispatch_take) begin
            op_q[dispatch.tag]  <= dispatch.op;
            imm_q[dispatch.tag] <= dispatch.imm;
            rs1_q[dispatch.tag] <= wake(dispatch.rs1, ex_bcast, result);
            rs2_q[dispatch.tag] <= wake(dispatch.rs2, ex_bcast, result);
        end
    end

    always_ff @(posedge clk) begin
        mem_req <= req_next;
        if (reset || flush) begin
            mem_req.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        result.valid <= done_hit;
        result.tag   <= mem_resp.tag;
        result.data  <= mem_resp.rdata;
        if (reset || flush) begin
            result.valid <= 1'b0;
        end
    end

endmodule

/* rtl/lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

    // memory opcodes as decoded by dispatch
    typedef enum logic [3:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw,
        op_none
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    // value is only meaningful once ready is set
    typedef struct packed {
        logic                  ready;
        logic [`LSU_TAG_W-1:0] tag;
        logic [`LSU_XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [`LSU_TAG_W-1:0] tag;
        logic [`LSU_XLEN-1:0]  imm;
        operand_t              rs1;
        operand_t              rs2;
    } dispatch_t;

    // execute broadcast and load result broadcast
    typedef struct packed {
        logic                  valid;
        logic [`LSU_TAG_W-1:0] tag;
        logic [`LSU_XLEN-1:0]  data;
    } bcast_t;

    typedef struct packed {
        logic                  valid;
        logic [`LSU_TAG_W-1:0] tag;
    } commit_t;

    typedef struct packed {
        logic                  valid;
        logic                  store;
        logic [`LSU_TAG_W-1:0] tag;
        mem_size_e             size;
        logic                  sign;
        logic [`LSU_XLEN-1:0]  addr;
        logic [`LSU_XLEN-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  done;
        logic [`LSU_TAG_W-1:0] tag;
        logic [`LSU_XLEN-1:0]  rdata;
    } mem_resp_t;

endpackage

/* rtl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  lsu_pkg::dispatch_t dispatch,
    input  lsu_pkg::bcast_t    ex_bcast,
    input  lsu_pkg::commit_t   commit,
    output lsu_pkg::bcast_t    result,
    output logic               full
);

    // buffer to memory link
    lsu_pkg::mem_req_t  mem_req;
    lsu_pkg::mem_resp_t mem_resp;
    logic               mem_idle;

    load_store_buffer u_lsb (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .dispatch (dispatch),
        .ex_bcast (ex_bcast),
        .commit   (commit),
        .mem_idle (mem_idle),
        .mem_resp (mem_resp),
        .mem_req  (mem_req),
        .result   (result),
        .full     (full)
    );

    data_mem u_mem (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp),
        .mem_idle (mem_idle)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f lsu.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* test/lsu_props.sv */
`timescale 1ns/1ps

module lsu_props (
    input logic               clk,
    input logic               reset,
    input logic               flush,
    input lsu_pkg::dispatch_t dispatch,
    input lsu_pkg::commit_t   commit,
    input lsu_pkg::mem_req_t  mem_req,
    input lsu_pkg::bcast_t    result,
    input logic               full
);

    // failed properties so far
    int unsigned fail_count = 0;

    // memory goes busy right after a request
    a_req_single: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid |=> !mem_req.valid)
        else begin
            $error("memory request valid on two consecutive cycles");
            fail_count++;
        end

    a_result_clear: assert property (@(posedge clk)
        (reset || flush) |=> !result.valid)
        else begin
            $error("result broadcast valid right after reset or flush");
            fail_count++;
        end

    // dispatcher holds off while every entry is taken
    a_full_no_dispatch: assert property (@(posedge clk) disable iff (reset)
        full |-> !dispatch.valid)
        else begin
            $error("dispatch valid while the buffer is full");
            fail_count++;
        end

    a_store_committed: assert property (@(posedge clk) disable iff (reset)
        (mem_req.valid && mem_req.store) |->
            ($past(commit.valid) && $past(commit.tag) == mem_req.tag))
        else begin
            $error("store request without a commit of its tag");
            fail_count++;
        end

endmodule

/* test/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_tb;

    localparam int NUM_ROWS = 14;
    localparam int TIMEOUT  = 60 * NUM_ROWS + 100;
    localparam int WAIT_MAX = 40;

    // rs1 readiness at dispatch
    localparam logic [1:0] RDY_NOW = 2'd0;
    localparam logic [1:0] RDY_EX  = 2'd1;
    localparam logic [1:0] RDY_OWN = 2'd2;

    localparam logic [1:0] K_STORE = 2'd0;
    localparam logic [1:0] K_LOAD  = 2'd1;
    localparam logic [1:0] K_FILL  = 2'd2;

    typedef struct packed {
        lsu_pkg::mem_op_e      op;
        logic [`LSU_TAG_W-1:0] tag;
        logic [`LSU_XLEN-1:0]  base;
        logic [`LSU_XLEN-1:0]  imm;
        logic [1:0]            rdy;
        logic                  cmt;
        logic [1:0]            kind;
    } row_t;

    logic               clk;
    logic               reset;
    logic               flush;
    lsu_pkg::dispatch_t dispatch;
    lsu_pkg::bcast_t    ex_bcast;
    lsu_pkg::commit_t   commit;
    lsu_pkg::bcast_t    result;
    logic               full;

    row_t        rows [NUM_ROWS];
    logic [7:0]  ref_mem [256];
    logic [15:0] lfsr;
    int          errors;
    int          failed_tests;
    int          cycle_count = 0;

    lsu_top DUT (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .dispatch (dispatch),
        .ex_bcast (ex_bcast),
        .commit   (commit),
        .result   (result),
        .full     (full)
    );

    bind load_store_buffer lsu_props u_props (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .dispatch (dispatch),
        .commit   (commit),
        .mem_req  (mem_req),
        .result   (result),
        .full     (full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [`LSU_XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[`LSU_XLEN-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int store_width(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::op_sb: return 8;
            lsu_pkg::op_sh: return 16;
            default:        return 32;
        endcase
    endfunction

    // little-endian byte model with sign or zero extension
    function automatic logic [31:0] ref_load(input lsu_pkg::mem_op_e op, input logic [31:0] addr);
        logic [7:0] a;
        logic [7:0] b1;
        logic [7:0] h1;
        a  = addr[7:0];
        b1 = ref_mem[a + 8'd1];
        h1 = ref_mem[a + 8'd3];
        case (op)
            lsu_pkg::op_lb:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
            lsu_pkg::op_lbu: return {24'h0, ref_mem[a]};
            lsu_pkg::op_lh:  return {{16{b1[7]}}, b1, ref_mem[a]};
            lsu_pkg::op_lhu: return {16'h0, b1, ref_mem[a]};
            default:         return {h1, ref_mem[a + 8'd2], b1, ref_mem[a]};
        endcase
    endfunction

    task automatic ref_store(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
        logic [7:0] a;
        a = addr[7:0];
        ref_mem[a] = data[7:0];
        if (op != lsu_pkg::op_sb) begin
            ref_mem[a + 8'd1] = data[15:8];
        end
        if (op == lsu_pkg::op_sw) begin
            ref_mem[a + 8'd2] = data[23:16];
            ref_mem[a + 8'd3] = data[31:24];
        end
    endtask

    function automatic lsu_pkg::bcast_t make_bcast(input logic [`LSU_TAG_W-1:0] tag,
                                                   input logic [`LSU_XLEN-1:0] data);
        lsu_pkg::bcast_t b;
        b.valid = 1'b1;
        b.tag   = tag;
        b.data  = data;
        return b;
    endfunction

    // compare failures plus failed properties
    function automatic int total_errors();
        return errors + int'(DUT.u_lsb.u_props.fail_count);
    endfunction

    task automatic check_bcast(input string name, input lsu_pkg::bcast_t got,
                               input lsu_pkg::bcast_t want);
        if (got.valid !== want.valid ||
            (want.valid && (got.tag !== want.tag || got.data !== want.data))) begin
            $display("MISMATCH %s: got valid %h tag %h data %h, expected valid %h tag %h data %h",
                     name, got.valid, got.tag, got.data, want.valid, want.tag, want.data);
            errors++;
        end
    endtask

    task automatic check_full(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("MISMATCH %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic send_dispatch(input lsu_pkg::mem_op_e op, input logic [`LSU_TAG_W-1:0] tag,
                                 input logic [31:0] imm, input logic rs1_rdy,
                                 input logic [`LSU_TAG_W-1:0] rs1_tag,
                                 input logic [31:0] rs1_val, input logic [31:0] rs2_val);
        dispatch.valid     = 1'b1;
        dispatch.op        = op;
        dispatch.tag       = tag;
        dispatch.imm       = imm;
        dispatch.rs1.ready = rs1_rdy;
        dispatch.rs1.tag   = rs1_tag;
        dispatch.rs1.value = rs1_val;
        dispatch.rs2.ready = 1'b1;
        dispatch.rs2.tag   = '0;
        dispatch.rs2.value = rs2_val;
    endtask

    // result must stay quiet for n cycles
    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_bcast("result", result, '0);
        end
    endtask

    task automatic expect_result(input lsu_pkg::bcast_t want, output int edges);
        lsu_pkg::bcast_t got;
        got   = '0;
        edges = 0;
        while (!got.valid && edges < WAIT_MAX) begin
            @(negedge clk);
            edges++;
            if (result.valid) begin
                got = result;
            end
        end
        if (!got.valid) begin
            $display("no result for tag %0d within %0d cycles", want.tag, WAIT_MAX);
            errors++;
        end else begin
            check_bcast("result", got, want);
        end
    endtask

    task automatic run_row(input int idx);
        row_t                  r;
        logic [`LSU_XLEN-1:0]  data;
        logic [`LSU_XLEN-1:0]  word;
        logic [`LSU_TAG_W-1:0] ptag;
        int                    edges;
        int                    start_errors;
        r            = rows[idx];
        start_errors = total_errors();
        ptag         = r.tag ^ `LSU_TAG_W'(4);
        case (r.kind)
            K_STORE: begin
                take_bits(store_width(r.op), data);
                send_dispatch(r.op, r.tag, r.imm, 1'b1, '0, r.base, data);
                @(negedge clk);
                dispatch.valid = 1'b0;
                if (r.cmt) begin
                    ref_store(r.op, r.base + r.imm, data);
                    commit.valid = 1'b1;
                    commit.tag   = r.tag;
                    edges        = 0;
                    // repeat the commit until the entry leaves
                    while (DUT.u_lsb.occupied[r.tag] && edges < WAIT_MAX) begin
                        @(negedge clk);
                        edges++;
                        check_bcast("result", result, '0);
                    end
                    commit.valid = 1'b0;
                    if (DUT.u_lsb.occupied[r.tag]) begin
                        $display("store with tag %0d never left the buffer", r.tag);
                        errors++;
                    end
                end
            end
            K_LOAD: begin
                if (r.rdy == RDY_NOW) begin
                    send_dispatch(r.op, r.tag, r.imm, 1'b1, '0, r.base, '0);
                    @(negedge clk);
                    dispatch.valid = 1'b0;
                    expect_result(make_bcast(r.tag, ref_load(r.op, r.base + r.imm)), edges);
                    if (edges != 5) begin
                        $display("MISMATCH load latency: got %h expected %h", edges, 5);
                        errors++;
                    end
                end else if (r.rdy == RDY_EX) begin
                    send_dispatch(r.op, r.tag, r.imm, 1'b0, ptag, '0, '0);
                    @(negedge clk);
                    dispatch.valid = 1'b0;
                    quiet_cycles(8);
                    ex_bcast = make_bcast(ptag, r.base);
                    @(negedge clk);
                    ex_bcast.valid = 1'b0;
                    expect_result(make_bcast(r.tag, ref_load(r.op, r.base + r.imm)), edges);
                end else begin
                    // producer load feeds the address of the dependent one
                    send_dispatch(lsu_pkg::op_lw, ptag, '0, 1'b1, '0, r.base, '0);
                    @(negedge clk);
                    send_dispatch(r.op, r.tag, r.imm, 1'b0, ptag, '0, '0);
                    @(negedge clk);
                    dispatch.valid = 1'b0;
                    word = ref_load(lsu_pkg::op_lw, r.base);
                    expect_result(make_bcast(ptag, word), edges);
                    expect_result(make_bcast(r.tag, ref_load(r.op, word + r.imm)), edges);
                end
            end
            default: begin
                // each entry waits on its own tag and no store is committed
                for (int i = 0; i < `LSU_ENTRIES; i++) begin
                    check_full("full", full, 1'b0);
                    send_dispatch((i % 2 == 1) ? lsu_pkg::op_sw : r.op, `LSU_TAG_W'(i),
                                  r.imm, 1'b0, `LSU_TAG_W'(i), '0, '0);
                    @(negedge clk);
                end
                dispatch.valid = 1'b0;
                check_full("full", full, 1'b1);
                // wake the load in entry 0 so it is in flight when the flush lands
                ex_bcast = make_bcast('0, r.base);
                @(negedge clk);
                ex_bcast.valid = 1'b0;
                quiet_cycles(2);
                check_full("full", full, 1'b1);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                check_full("full", full, 1'b0);
                quiet_cycles(10);
            end
        endcase
        quiet_cycles(3);
        if (total_errors() == start_errors) begin
            $display("test %0d %s tag %0d: pass", idx, r.op.name(), r.tag);
        end else begin
            $display("test %0d %s tag %0d: FAIL", idx, r.op.name(), r.tag);
            failed_tests++;
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{lsu_pkg::op_sw,  3'd0, 32'h40, 32'h04, RDY_NOW, 1'b1, K_STORE};
        rows[1]  = '{lsu_pkg::op_lw,  3'd1, 32'h40, 32'h04, RDY_NOW, 1'b0, K_LOAD};
        rows[2]  = '{lsu_pkg::op_sb,  3'd2, 32'h50, 32'h01, RDY_NOW, 1'b1, K_STORE};
        rows[3]  = '{lsu_pkg::op_sb,  3'd3, 32'h50, 32'h03, RDY_NOW, 1'b1, K_STORE};
        rows[4]  = '{lsu_pkg::op_sh,  3'd4, 32'h54, 32'h02, RDY_NOW, 1'b1, K_STORE};
        rows[5]  = '{lsu_pkg::op_lb,  3'd5, 32'h50, 32'h01, RDY_NOW, 1'b0, K_LOAD};
        rows[6]  = '{lsu_pkg::op_lbu, 3'd6, 32'h50, 32'h03, RDY_NOW, 1'b0, K_LOAD};
        rows[7]  = '{lsu_pkg::op_lh,  3'd7, 32'h54, 32'h02, RDY_NOW, 1'b0, K_LOAD};
        rows[8]  = '{lsu_pkg::op_lhu, 3'd0, 32'h54, 32'h02, RDY_NOW, 1'b0, K_LOAD};
        rows[9]  = '{lsu_pkg::op_lw,  3'd3, 32'h3c, 32'h08, RDY_EX,  1'b0, K_LOAD};
        rows[10] = '{lsu_pkg::op_lbu, 3'd6, 32'h44, 32'h03, RDY_OWN, 1'b0, K_LOAD};
        rows[11] = '{lsu_pkg::op_lw,  3'd0, 32'h00, 32'h00, RDY_EX,  1'b0, K_FILL};
        rows[12] = '{lsu_pkg::op_sh,  3'd5, 32'h60, 32'h06, RDY_NOW, 1'b1, K_STORE};
        rows[13] = '{lsu_pkg::op_lh,  3'd2, 32'h60, 32'h06, RDY_NOW, 1'b0, K_LOAD};
    endtask

    initial begin
        reset        = 1'b1;
        flush        = 1'b0;
        dispatch     = '0;
        ex_bcast     = '0;
        commit       = '0;
        lfsr         = 16'd52;
        errors       = 0;
        failed_tests = 0;
        ref_mem      = '{default: 8'h00};
        fill_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("tests %0d, failed %0d, errors %0d", NUM_ROWS, failed_tests, total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
